/* design/bus_meter.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mini_soc_settings.svh"

module bus_meter (
	input wire sys_clk,
	input wire sys_rst_i,
	input wire soc_pkg::csr_addr_t csr_a_i,
	input wire csr_we_i,
	input wire [31:0] csr_dw_i,
	input wire wb_stb_i,
	input wire wb_cyc_i,
	input wire wb_ack_i,
	output logic [31:0] csr_dr_o
);

	logic csr_sel;
	logic ctrl_wr;
	logic meter_en;
	logic [31:0] stb_count;
	logic [31:0] ack_count;

	assign csr_sel = (csr_a_i.field.bank == `CSR_BANK_METER);
	assign ctrl_wr = csr_we_i & csr_sel & (csr_a_i.field.regnum == `METER_REG_CTRL);

	// Bit 0 enables counting, bit 1 clears both counters
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			meter_en <= 1'b0;
			stb_count <= 32'd0;
			ack_count <= 32'd0;
		end else begin
			if (ctrl_wr) begin
				meter_en <= csr_dw_i[0];
			end
			if (ctrl_wr && csr_dw_i[1]) begin
				stb_count <= 32'd0;
				ack_count <= 32'd0;
			end else if (meter_en) begin
				stb_count <= stb_count + {31'd0, wb_cyc_i & wb_stb_i};
				ack_count <= ack_count + {31'd0, wb_ack_i};
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (csr_sel) begin
			case (csr_a_i.field.regnum)
				`METER_REG_CTRL: csr_dr_o <= {31'd0, meter_en};
				`METER_REG_STB_COUNT: csr_dr_o <= stb_count;
				`METER_REG_ACK_COUNT: csr_dr_o <= ack_count;
				default: csr_dr_o <= 32'd0;
			endcase
		end else begin
			csr_dr_o <= 32'd0;
		end
	end

endmodule

`default_nettype wire

/* design/csr_bridge.sv */
`default_nettype none
`timescale 1ns/1ns

module csr_bridge (
	input wire sys_clk,
	input wire sys_rst_i,
	input wire [31:0] wb_adr_i,
	input wire [31:0] wb_dat_i,
	input wire wb_we_i,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	output soc_pkg::csr_addr_t csr_a_o,
	output logic csr_we_o,
	output logic [31:0] csr_dw_o,
	input wire [31:0] csr_dr_sysctl_i,
	input wire [31:0] csr_dr_meter_i
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_WRITE = 3'd1;
	localparam logic [2:0] ST_READ_ADDR = 3'd2;
	localparam logic [2:0] ST_READ_DATA = 3'd3;
	localparam logic [2:0] ST_DONE = 3'd4;

	logic [2:0] state;
	logic wb_start;

	assign wb_start = (state == ST_IDLE) & wb_cyc_i & wb_stb_i;

	// ----------------------------------------
	// Transfer FSM
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			wb_ack_o <= 1'b0;
			csr_we_o <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			csr_we_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wb_start) begin
						csr_we_o <= wb_we_i;
						state <= wb_we_i ? ST_WRITE : ST_READ_ADDR;
					end
				end
				// CSR write happens this cycle
				ST_WRITE: begin
					wb_ack_o <= 1'b1;
					state <= ST_DONE;
				end
				// Banks register their read word
				ST_READ_ADDR: state <= ST_READ_DATA;
				ST_READ_DATA: begin
					wb_ack_o <= 1'b1;
					state <= ST_DONE;
				end
				// Master still holds stb while it sees ack
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address, write data and read data
	always_ff @(posedge sys_clk) begin
		if (wb_start) begin
			csr_a_o.word <= wb_adr_i[15:2];
			csr_dw_o <= wb_dat_i;
		end
		// Unselected banks return zero
		if (state == ST_READ_DATA) begin
			wb_dat_o <= csr_dr_sysctl_i | csr_dr_meter_i;
		end
	end

endmodule

`default_nettype wire

/* design/mini_soc_top.sv */
`default_nettype none
`timescale 1ns/1ns

module mini_soc_top (
	input wire sys_clk,
	input wire trigger_reset,
	input wire [31:0] wb_adr_i,
	input wire [31:0] wb_dat_i,
	input wire wb_we_i,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire [2:0] btn_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	output logic [1:0] led_o,
	output logic [31:0] irq_o,
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);

	import soc_pkg::*;

	wire sys_rst;
	wire hard_reset;
	wire gpio_irq;
	wire timer0_irq;

	csr_addr_t csr_a;
	wire csr_we;
	wire [31:0] csr_dw;
	wire [31:0] csr_dr_sysctl;
	wire [31:0] csr_dr_meter;

	// ----------------------------------------
	// Reset
	// ----------------------------------------
	reset_sequencer u_reset_sequencer (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.btn_i(btn_i),
		.hard_reset_i(hard_reset),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// ----------------------------------------
	// Wishbone to CSR
	// ----------------------------------------
	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.csr_a_o(csr_a),
		.csr_we_o(csr_we),
		.csr_dw_o(csr_dw),
		.csr_dr_sysctl_i(csr_dr_sysctl),
		.csr_dr_meter_i(csr_dr_meter)
	);

	// ----------------------------------------
	// CSR banks
	// ----------------------------------------
	system_controller u_system_controller (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_dw_i(csr_dw),
		.btn_i(btn_i),
		.csr_dr_o(csr_dr_sysctl),
		.led_o(led_o),
		.gpio_irq_o(gpio_irq),
		.timer0_irq_o(timer0_irq),
		.hard_reset_o(hard_reset)
	);

	// Watches the bridge port including its own accesses
	bus_meter u_bus_meter (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_dw_i(csr_dw),
		.wb_stb_i(wb_stb_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_ack_i(wb_ack_o),
		.csr_dr_o(csr_dr_meter)
	);

	// Interrupt vector with unused lines held low
	always_comb begin
		irq_o = 32'd0;
		irq_o[IRQ_GPIO] = gpio_irq;
		irq_o[IRQ_TIMER0] = timer0_irq;
	end

endmodule

`default_nettype wire

/* design/reset_sequencer.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mini_soc_settings.svh"

module reset_sequencer (
	input wire sys_clk,
	input wire trigger_reset,
	input wire [2:0] btn_i,
	input wire hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	localparam int DEB_W = $clog2(`RST_DEBOUNCE_CYCLES + 1);
	localparam int FLASH_W = $clog2(`FLASH_RST_CYCLES + 1);
	localparam logic [DEB_W-1:0] DEB_LOAD = DEB_W'(`RST_DEBOUNCE_CYCLES);
	localparam logic [FLASH_W-1:0] FLASH_DONE = FLASH_W'(`FLASH_RST_CYCLES);

	logic rst_req;
	logic [DEB_W-1:0] debounce_cnt;
	logic [FLASH_W-1:0] flash_cnt;

	// All three buttons together act as a reset button
	always_ff @(posedge sys_clk) begin
		rst_req <= trigger_reset | (&btn_i) | hard_reset_i;
	end

	// ----------------------------------------
	// System reset debounce
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			debounce_cnt <= DEB_LOAD;
		end else if (debounce_cnt != '0) begin
			debounce_cnt <= debounce_cnt - 1'b1;
		end
	end

	assign sys_rst_o = rst_req | (debounce_cnt != '0);

	// ----------------------------------------
	// Early flash release
	// ----------------------------------------
	// The flash needs time to recover before the first access,
	// so it counts up to a shorter limit than the debounce
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			flash_cnt <= '0;
		end else if (flash_cnt != FLASH_DONE) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	assign flash_rst_n_o = (flash_cnt == FLASH_DONE);

endmodule

`default_nettype wire

/* design/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// Bank and register view of a CSR word address
	typedef struct packed {
		logic [3:0] bank;
		logic [9:0] regnum;
	} csr_field_t;

	// The bridge only sees the raw word, the banks decode the fields
	typedef union packed {
		logic [13:0] word;
		csr_field_t field;
	} csr_addr_t;

	// ----------------------------------------
	// Interrupt vector bit positions
	// ----------------------------------------
	parameter int IRQ_GPIO = 0;
	parameter int IRQ_TIMER0 = 1;

endpackage

`default_nettype wire

/* design/system_controller.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mini_soc_settings.svh"

module system_controller (
	input wire sys_clk,
	input wire sys_rst_i,
	input wire soc_pkg::csr_addr_t csr_a_i,
	input wire csr_we_i,
	input wire [31:0] csr_dw_i,
	input wire [2:0] btn_i,
	output logic [31:0] csr_dr_o,
	output logic [1:0] led_o,
	output logic gpio_irq_o,
	output logic timer0_irq_o,
	output logic hard_reset_o
);

	logic csr_sel;
	logic csr_wr;

	logic [2:0] btn_meta;
	logic [2:0] btn_sync;
	logic [2:0] btn_prev;
	logic btn_change;

	logic gpio_irq_en;
	logic timer_en;
	logic [31:0] timer_cmp;
	logic [31:0] timer_cnt;

	assign csr_sel = (csr_a_i.field.bank == `CSR_BANK_SYSCTL);
	assign csr_wr = csr_we_i & csr_sel;

	// ----------------------------------------
	// Button inputs
	// ----------------------------------------
	// Two-flop synchronizer, then a third stage for edges
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	assign btn_change = (btn_sync != btn_prev);

	// ----------------------------------------
	// Control registers and timer
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= 2'b00;
			gpio_irq_en <= 1'b0;
			timer_en <= 1'b0;
			timer_cmp <= 32'd0;
			timer_cnt <= 32'd0;
			gpio_irq_o <= 1'b0;
			timer0_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;
		end else begin
			gpio_irq_o <= gpio_irq_en & btn_change;
			timer0_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;

			// One-shot timer that stops itself on match
			if (timer_en) begin
				if (timer_cnt == timer_cmp) begin
					timer_cnt <= 32'd0;
					timer_en <= 1'b0;
					timer0_irq_o <= 1'b1;
				end else begin
					timer_cnt <= timer_cnt + 32'd1;
				end
			end

			// Bus writes win over the timer update
			if (csr_wr) begin
				case (csr_a_i.field.regnum)
					`SYSCTL_REG_GPIO_OUT: led_o <= csr_dw_i[1:0];
					`SYSCTL_REG_IRQ_EN: gpio_irq_en <= csr_dw_i[0];
					`SYSCTL_REG_TIMER_CTRL: timer_en <= csr_dw_i[0];
					`SYSCTL_REG_TIMER_CMP: timer_cmp <= csr_dw_i;
					`SYSCTL_REG_TIMER_CNT: timer_cnt <= csr_dw_i;
					// Any value written here restarts the system
					`SYSCTL_REG_HARD_RESET: hard_reset_o <= 1'b1;
					default: begin
					end
				endcase
			end
		end
	end

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (csr_sel) begin
			case (csr_a_i.field.regnum)
				`SYSCTL_REG_GPIO_IN: csr_dr_o <= {29'd0, btn_sync};
				`SYSCTL_REG_GPIO_OUT: csr_dr_o <= {30'd0, led_o};
				`SYSCTL_REG_IRQ_EN: csr_dr_o <= {31'd0, gpio_irq_en};
				`SYSCTL_REG_TIMER_CTRL: csr_dr_o <= {31'd0, timer_en};
				`SYSCTL_REG_TIMER_CMP: csr_dr_o <= timer_cmp;
				`SYSCTL_REG_TIMER_CNT: csr_dr_o <= timer_cnt;
				`SYSCTL_REG_SYSTEM_ID: csr_dr_o <= `SYSTEM_ID;
				default: csr_dr_o <= 32'd0;
			endcase
		end else begin
			csr_dr_o <= 32'd0;
		end
	end

endmodule

`default_nettype wire

/* include/mini_soc_settings.svh */
`ifndef MINI_SOC_SETTINGS_SVH
`define MINI_SOC_SETTINGS_SVH

// Reset timing in sys_clk cycles
`define RST_DEBOUNCE_CYCLES 200
// Flash leaves reset well before the system does
`define FLASH_RST_CYCLES 128

// CSR bank numbers
`define CSR_BANK_SYSCTL 4'd0
`define CSR_BANK_METER 4'd1

// System controller registers
`define SYSCTL_REG_GPIO_IN 10'd0
`define SYSCTL_REG_GPIO_OUT 10'd1
`define SYSCTL_REG_IRQ_EN 10'd2
`define SYSCTL_REG_TIMER_CTRL 10'd3
`define SYSCTL_REG_TIMER_CMP 10'd4
`define SYSCTL_REG_TIMER_CNT 10'd5
`define SYSCTL_REG_SYSTEM_ID 10'd6
`define SYSCTL_REG_HARD_RESET 10'd7

// Bus meter registers
`define METER_REG_CTRL 10'd0
`define METER_REG_STB_COUNT 10'd1
`define METER_REG_ACK_COUNT 10'd2

// Reads as "SOC1"
`define SYSTEM_ID 32'h534f_4331

`endif

/* mini_soc.f */
+incdir+include
design/soc_pkg.sv
design/reset_sequencer.sv
design/csr_bridge.sv
design/system_controller.sv
design/bus_meter.sv
design/mini_soc_top.sv
testbench/tb_mini_soc.sv

/* run_mini_soc.sh */
#!/usr/bin/env bash
# Build and run the mini SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_mini_soc \
	-f mini_soc.f \
	-o tb_mini_soc

output=$(./obj_dir/tb_mini_soc)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

/* testbench/mini_soc_tests.txt */
# Columns: name, op, address (hex), data (hex), expected (hex)
# Ops: W write, R read equal, G read at least, L LFSR word to LED, B buttons,
# I interrupt bit in address (data 1 pulse, 0 none), X wait for reset release
reset_release      X 0    0  0
sysid_read         R 0018 0  534f4331
led_lfsr_a         L 0004 0  0
led_lfsr_b         L 0004 0  0
gpio_in_idle       R 0000 0  0
timer_cmp_set      W 0010 14 0
timer_start        W 000c 1  0
timer_irq          I 1    1  0
timer_cnt_zero     R 0014 0  0
timer_en_clear     R 000c 0  0
gpio_irq_enable    W 0008 1  0
btn_press          B 0    1  0
gpio_irq_pulse     I 0    1  0
gpio_in_pressed    R 0000 0  1
gpio_irq_disable   W 0008 0  0
btn_release        B 0    0  0
gpio_irq_quiet     I 0    0  0
gpio_in_released   R 0000 0  0
meter_start        W 1000 3  0
meter_xfer_1       R 0018 0  534f4331
meter_xfer_2       W 0004 2  0
meter_xfer_3       R 0004 0  2
meter_stop         W 1000 0  0
meter_ack_count    R 1008 0  4
meter_stb_count    G 1004 0  4
led_before_hrst    W 0004 3  0
hard_reset_write   W 001c 1  0
hard_reset_release X 0    0  0
led_after_hrst     R 0004 0  0

/* testbench/tb_mini_soc.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_mini_soc;

	localparam int ACK_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 100;
	localparam int RESET_TIMEOUT = 400;

	logic sys_clk;
	logic trigger_reset;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic [2:0] btn;
	wire [31:0] wb_dat_r;
	wire wb_ack;
	wire [1:0] led;
	wire [31:0] irq;
	wire flash_rst_n;
	wire periph_rst_n;

	logic [31:0] lfsr_state;
	int errors;
	int tests;
	int failed;

	mini_soc_top DUT (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_we_i(wb_we),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.btn_i(btn),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.led_o(led),
		.irq_o(irq),
		.flash_rst_n_o(flash_rst_n),
		.periph_rst_n_o(periph_rst_n)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// ----------------------------------------
	// Random data
	// ----------------------------------------
	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] random_word();
		logic [31:0] w;
		w = 32'd0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
		return w;
	endfunction

	// ----------------------------------------
	// Wishbone master
	// ----------------------------------------
	task automatic wb_transfer(input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic ok);
		int cycles;
		@(posedge sys_clk);
		#1;
		wb_adr = addr;
		wb_dat_w = wdata;
		wb_we = we;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		cycles = 0;
		ok = 1'b0;
		rdata = 32'd0;
		while (!ok && cycles < ACK_TIMEOUT) begin
			@(posedge sys_clk);
			#1;
			if (wb_ack === 1'b1) begin
				ok = 1'b1;
				rdata = wb_dat_r;
			end
			cycles++;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!ok) begin
			$display("%s: no Wishbone ack within %0d cycles", addr_text(addr), ACK_TIMEOUT);
			errors++;
		end
	endtask

	function automatic string addr_text(input logic [31:0] addr);
		return $sformatf("address %h", addr);
	endfunction

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] got);
		assert (got === expected) else begin
			$display("MISMATCH %s expected %h actual %h", name, expected, got);
			errors++;
		end
	endtask

	task automatic check_at_least(input string name, input logic [31:0] expected,
			input logic [31:0] got);
		assert (got >= expected) else begin
			$display("MISMATCH %s expected at least %h actual %h", name, expected, got);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Waits on reset and interrupts
	// ----------------------------------------
	task automatic wait_reset_release(input string name);
		int cycles;
		logic flash_first;
		cycles = 0;
		flash_first = 1'b0;
		// Both resets active before the release is timed
		while (!(periph_rst_n === 1'b0 && flash_rst_n === 1'b0) && cycles < ACK_TIMEOUT) begin
			@(posedge sys_clk);
			#1;
			cycles++;
		end
		if (!(periph_rst_n === 1'b0 && flash_rst_n === 1'b0)) begin
			$display("%s: reset never became active", name);
			errors++;
			return;
		end
		cycles = 0;
		while (periph_rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
			if (flash_rst_n === 1'b1) begin
				flash_first = 1'b1;
			end
			@(posedge sys_clk);
			#1;
			cycles++;
		end
		if (periph_rst_n !== 1'b1) begin
			$display("%s: peripheral reset not released within %0d cycles", name, RESET_TIMEOUT);
			errors++;
		end else begin
			assert (flash_first) else begin
				$display("%s: flash reset was not released before the peripheral reset", name);
				errors++;
			end
		end
	endtask

	task automatic watch_irq(input string name, input logic [4:0] bit_pos, input logic want);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < IRQ_TIMEOUT) begin
			@(posedge sys_clk);
			#1;
			seen = (irq[bit_pos] === 1'b1);
			cycles++;
		end
		if (want && !seen) begin
			$display("%s: interrupt bit %0d did not pulse within %0d cycles", name, bit_pos,
				IRQ_TIMEOUT);
			errors++;
		end else if (!want) begin
			assert (!seen) else begin
				$display("%s: interrupt bit %0d pulsed although it was disabled", name,
					bit_pos);
				errors++;
			end
		end
	endtask

	// ----------------------------------------
	// One line of the test file
	// ----------------------------------------
	task automatic run_step(input string name, input string op, input logic [31:0] addr,
			input logic [31:0] data, input logic [31:0] expected);
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic ok;
		if (op == "W") begin
			wb_transfer(1'b1, addr, data, rdata, ok);
		end else if (op == "R" || op == "G") begin
			wb_transfer(1'b0, addr, 32'd0, rdata, ok);
			if (ok && op == "R") begin
				check_equal(name, expected, rdata);
			end else if (ok) begin
				check_at_least(name, expected, rdata);
			end
		end else if (op == "L") begin
			// LEDs show the two low bits of the written word
			wdata = random_word();
			wb_transfer(1'b1, addr, wdata, rdata, ok);
			check_equal(name, {30'd0, wdata[1:0]}, {30'd0, led});
			wb_transfer(1'b0, addr, 32'd0, rdata, ok);
			if (ok) begin
				check_equal(name, {30'd0, wdata[1:0]}, rdata);
			end
		end else if (op == "B") begin
			@(posedge sys_clk);
			#1;
			btn = data[2:0];
		end else if (op == "I") begin
			watch_irq(name, addr[4:0], data[0]);
		end else if (op == "X") begin
			wait_reset_release(name);
		end else begin
			$display("%s: unknown operation %s", name, op);
			errors++;
		end
	endtask

	initial begin
		int fd;
		int fields;
		int errors_before;
		string line;
		string name;
		string op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expected;

		trigger_reset = 1'b1;
		wb_adr = 32'd0;
		wb_dat_w = 32'd0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		btn = 3'b000;
		lfsr_state = 32'h28a4_2ca1;
		errors = 0;
		tests = 0;
		failed = 0;
		repeat (3) @(posedge sys_clk);
		#1;
		trigger_reset = 1'b0;

		fd = $fopen("testbench/mini_soc_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test file testbench/mini_soc_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) == 0) begin
					break;
				end
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				fields = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, expected);
				if (fields != 5) begin
					$display("Malformed line in the test file: %s", line);
					errors++;
					continue;
				end
				errors_before = errors;
				run_step(name, op, addr, data, expected);
				tests++;
				if (errors == errors_before) begin
					$display("PASS %s", name);
				end else begin
					failed++;
					$display("FAIL %s", name);
				end
			end
			$fclose(fd);
		end

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0 && tests > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
